/* build.f */
+incdir+.
softermax_pkg.sv
softermax_local_window.sv
softermax_norm_divider.sv
softermax_global_norm.sv
softermax_output_cast.sv
softermax_top.sv
softermax_checker.sv
tb_softermax.sv

/* run_sim.sh */
#!/bin/sh
# Builds the softmax testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_softermax
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_softermax)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

/* tb_softermax.sv */
// Softmax unit testbench with LFSR vectors, a reference model and a watchdog
// Expected beats go to the checker, which compares the DUT output
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module tb_softermax
    import softermax_pkg::*;
();

    localparam int par             = `SM_PARALLELISM;
    localparam int depth           = `SM_DEPTH;
    localparam int random_vectors  = 200;
    localparam int num_vectors     = random_vectors + 4;
    localparam int max_beats       = num_vectors * depth;
    localparam int vector_cycles   = 4 * (2 * depth + `SM_RECIP_WIDTH + 8);
    localparam int watchdog_cycles = num_vectors * vector_cycles + 1000;

    logic                    clk;
    logic                    reset;
    in_elem_t  [par-1:0]     in_data;
    logic                    in_valid;
    logic                    in_ready;
    out_elem_t [par-1:0]     out_data;
    logic                    out_valid;
    logic                    out_ready;

    out_elem_t [par-1:0]     exp_mem [max_beats];
    int                      exp_count;
    int                      pending;
    logic                    end_check;
    int                      value_errors;
    int                      protocol_errors;
    int                      stim_errors;
    logic [31:0]             lfsr;
    int                      ready_mode;
    bit                      gaps_on;
    in_elem_t                vec_in [`SM_TOTAL_DIM];

    softermax_top softermax_top_inst (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    softermax_checker #(
        .max_beats (max_beats)
    ) softermax_checker_inst (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .out_data        (out_data),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .exp_mem         (exp_mem),
        .exp_count       (exp_count),
        .end_check       (end_check),
        .pending         (pending),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic void drive_ready();
        case (ready_mode)
            0:       out_ready = 1'b1;
            1:       out_ready = |take_bits(2);
            default: out_ready = 1'b0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        drive_ready();
    endtask

    task automatic send_beat(input in_elem_t [par-1:0] beat);
        bit done;
        while (gaps_on && take_bits(2) == 32'd0) begin
            in_valid = 1'b0;
            next_cycle();
        end
        in_data  = beat;
        in_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            #1;
            done = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    task automatic send_vector();
        in_elem_t [par-1:0] beat;
        for (int b = 0; b < depth; b++) begin
            for (int i = 0; i < par; i++) begin
                beat[i] = vec_in[b * par + i];
            end
            send_beat(beat);
        end
    endtask

    task automatic push_expected(input out_elem_t [par-1:0] word);
        exp_mem[exp_count] = word;
        exp_count++;
    endtask

    task automatic model_vector();
        int                  lmax [depth];
        int                  value [`SM_TOTAL_DIM];
        int                  gmax;
        int                  x;
        int                  d;
        longint              sum;
        longint              prod;
        out_elem_t [par-1:0] word;
        gmax = -1000;
        for (int b = 0; b < depth; b++) begin
            lmax[b] = -1000;
            for (int i = 0; i < par; i++) begin
                x = int'(vec_in[b * par + i]) >>> `SM_IN_FRAC;
                if (x > lmax[b]) begin
                    lmax[b] = x;
                end
            end
            if (lmax[b] > gmax) begin
                gmax = lmax[b];
            end
            // d splits into k = floor(d/8) <= 0 and eighths d & 7
            for (int i = 0; i < par; i++) begin
                d = int'(vec_in[b * par + i]) - (lmax[b] << `SM_IN_FRAC);
                if (-(d >>> 3) >= 16) begin
                    value[b * par + i] = 0;
                end else begin
                    value[b * par + i] = ((8 + (d & 7)) << 12) >> (-(d >>> 3));
                end
            end
        end
        sum = 0;
        for (int j = 0; j < `SM_TOTAL_DIM; j++) begin
            value[j] = value[j] >> (gmax - lmax[j / par]);
            sum      = sum + value[j];
        end
        for (int b = 0; b < depth; b++) begin
            for (int i = 0; i < par; i++) begin
                prod    = longint'(value[b * par + i]) * ((longint'(1) << 30) / sum);
                word[i] = (prod >> 23) > 255 ? 8'hff : out_elem_t'(prod >> 23);
            end
            push_expected(word);
        end
    endtask

    task automatic random_vector();
        logic [31:0] bits;
        logic        narrow;
        // Half the vectors stay near zero so fractions matter
        narrow = |take_bits(1);
        for (int j = 0; j < `SM_TOTAL_DIM; j++) begin
            bits      = take_bits(8);
            vec_in[j] = narrow ? in_elem_t'({{2{bits[5]}}, bits[5:0]}) : in_elem_t'(bits[7:0]);
        end
        model_vector();
        send_vector();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < 2 * vector_cycles) begin
            next_cycle();
            cycles++;
        end
    endtask

    initial begin
        reset       = 1'b1;
        in_data     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        end_check   = 1'b0;
        exp_count   = 0;
        stim_errors = 0;
        lfsr        = 32'h3649;
        ready_mode  = 0;
        gaps_on     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_ready();

        // All equal inputs give 1.0 per value, a sum of 16 and a reciprocal of 1/16
        for (int j = 0; j < `SM_TOTAL_DIM; j++) begin
            vec_in[j] = in_elem_t'(8'h10);
        end
        for (int b = 0; b < depth; b++) begin
            push_expected({par{8'h08}});
        end
        send_vector();

        // One spike at 15.875 among inputs of -16
        for (int j = 0; j < `SM_TOTAL_DIM; j++) begin
            vec_in[j] = in_elem_t'(j == 6 ? 8'h7f : 8'h80);
        end
        model_vector();
        send_vector();

        gaps_on = 1'b1;
        for (int v = 0; v < random_vectors; v++) begin
            ready_mode = (v < random_vectors / 2) ? 0 : 1;
            random_vector();
        end
        ready_mode = 0;
        wait_drain();

        // Hold out_ready low until the input side stalls
        gaps_on    = 1'b0;
        ready_mode = 2;
        fork
            begin
                random_vector();
                random_vector();
            end
            begin : release_ready
                int  waited;
                bit  stall_seen;
                waited     = 0;
                stall_seen = 1'b0;
                while (!stall_seen && waited < 2 * vector_cycles) begin
                    @(posedge clk);
                    #2;
                    stall_seen = in_valid && !in_ready && out_valid;
                    waited++;
                end
                if (!stall_seen) begin
                    $display("Error: in_ready never dropped while out_ready was held low");
                    stim_errors++;
                end
                repeat (10) @(posedge clk);
                #2;
                ready_mode = 0;
            end
        join
        wait_drain();

        end_check = 1'b1;
        repeat (2) next_cycle();
        $display("Errors: %0d value, %0d protocol, %0d stimulus over %0d beats",
                 value_errors, protocol_errors, stim_errors, exp_count);
        if (value_errors + protocol_errors + stim_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* softermax_checker.sv */
// Watches the softmax ports and compares each output beat with the expected list
// Expected beats are written by the testbench model before their inputs are sent
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_checker
    import softermax_pkg::*;
#(
    parameter int max_beats = 1024
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  logic                               in_ready,
    input  out_elem_t [`SM_PARALLELISM-1:0]    out_data,
    input  logic                               out_valid,
    input  logic                               out_ready,
    input  out_elem_t [`SM_PARALLELISM-1:0]    exp_mem [max_beats],
    input  int                                 exp_count,
    input  logic                               end_check,
    output int                                 pending,
    output int                                 value_errors,
    output int                                 protocol_errors
);

    int                                  rd_ptr = 0;
    int                                  in_beats = 0;
    int                                  value_count = 0;
    int                                  protocol_count = 0;
    logic                                reset_d = 1'b0;
    logic                                end_done = 1'b0;
    logic                                stalled;
    out_elem_t [`SM_PARALLELISM-1:0]     held_data;

    assign pending         = exp_count - rd_ptr;
    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;

    always @(posedge clk) begin
        if (reset_d && out_valid !== 1'b0) begin
            $display("Error at %0t: out_valid is not low during or right after reset", $time);
            protocol_count++;
        end
        reset_d = reset;
        if (reset) begin
            stalled = 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                in_beats++;
            end
            // A stalled beat has to stay in place
            if (stalled && (out_valid !== 1'b1 || out_data !== held_data)) begin
                $display("Error at %0t: output beat changed or vanished while stalled", $time);
                protocol_count++;
            end
            stalled   = out_valid && !out_ready;
            held_data = out_data;
            if (out_valid && out_ready) begin
                // A vector leaves only after all its beats went in
                if (in_beats < (rd_ptr / `SM_DEPTH + 1) * `SM_DEPTH) begin
                    $display("Error at %0t: output beat left before its whole vector was taken in",
                             $time);
                    protocol_count++;
                end
                if (rd_ptr >= exp_count) begin
                    $display("Error at %0t: output beat arrived with none expected", $time);
                    protocol_count++;
                end else begin
                    if (out_data !== exp_mem[rd_ptr]) begin
                        $display("Fail out_data at %0t: got %h, expected %h",
                                 $time, out_data, exp_mem[rd_ptr]);
                        value_count++;
                    end
                    rd_ptr++;
                end
            end
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (rd_ptr != exp_count) begin
                    $display("Error: %0d expected beats never came out", exp_count - rd_ptr);
                    protocol_count++;
                end
            end
        end
    end

endmodule

/* softermax_top.sv */
// Softmax unit top level: input window, global normalizer and output cast
// Vectors enter and leave as SM_DEPTH beats of SM_PARALLELISM lanes
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_top
    import softermax_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  in_elem_t  [`SM_PARALLELISM-1:0]    in_data,
    input  logic                               in_valid,
    output logic                               in_ready,
    output out_elem_t [`SM_PARALLELISM-1:0]    out_data,
    output logic                               out_valid,
    input  logic                               out_ready
);

    value_t [`SM_PARALLELISM-1:0]    win_values;
    max_t                            win_max;
    logic                            win_valid;
    logic                            win_ready;

    prod_t  [`SM_PARALLELISM-1:0]    norm_prod;
    logic                            norm_valid;
    logic                            norm_ready;

    softermax_local_window local_window_inst (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .win_values (win_values),
        .win_max    (win_max),
        .win_valid  (win_valid),
        .win_ready  (win_ready)
    );

    softermax_global_norm global_norm_inst (
        .clk        (clk),
        .reset      (reset),
        .win_values (win_values),
        .win_max    (win_max),
        .win_valid  (win_valid),
        .win_ready  (win_ready),
        .norm_prod  (norm_prod),
        .norm_valid (norm_valid),
        .norm_ready (norm_ready)
    );

    softermax_output_cast output_cast_inst (
        .clk        (clk),
        .reset      (reset),
        .norm_prod  (norm_prod),
        .norm_valid (norm_valid),
        .norm_ready (norm_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* softermax_output_cast.sv */
// Output stage: floors Q2.30 products to Q1.7 bytes with saturation
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_output_cast
    import softermax_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  prod_t     [`SM_PARALLELISM-1:0]    norm_prod,
    input  logic                               norm_valid,
    output logic                               norm_ready,
    output out_elem_t [`SM_PARALLELISM-1:0]    out_data,
    output logic                               out_valid,
    input  logic                               out_ready
);

    localparam int drop_bits = 2 * (`SM_VALUE_WIDTH - 1) - (`SM_OUT_WIDTH - 1);

    out_elem_t [`SM_PARALLELISM-1:0] cast_data;

    always_comb begin
        for (int i = 0; i < `SM_PARALLELISM; i++) begin
            // Anything at 2.0 or above clips
            if (|norm_prod[i][$bits(prod_t)-1:drop_bits+`SM_OUT_WIDTH]) begin
                cast_data[i] = '1;
            end else begin
                cast_data[i] = norm_prod[i][drop_bits+`SM_OUT_WIDTH-1:drop_bits];
            end
        end
    end

    assign norm_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (norm_ready) begin
            out_valid <= norm_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (norm_valid && norm_ready) begin
            out_data <= cast_data;
        end
    end

endmodule

/* softermax_global_norm.sv */
// Processing stage: global max, renormalizing shift, sum, reciprocal and multiply
// Holds one vector; takes the next only after the last product beat has left
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_global_norm
    import softermax_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  value_t   [`SM_PARALLELISM-1:0]    win_values,
    input  max_t                              win_max,
    input  logic                              win_valid,
    output logic                              win_ready,
    output prod_t    [`SM_PARALLELISM-1:0]    norm_prod,
    output logic                              norm_valid,
    input  logic                              norm_ready
);

    localparam int beat_bits = $clog2(`SM_DEPTH);

    norm_state_t                     state;
    logic [beat_bits-1:0]            beat_cnt;
    logic                            last_beat;

    value_t [`SM_PARALLELISM-1:0]    value_mem [`SM_DEPTH];
    max_t                            max_mem [`SM_DEPTH];
    max_t                            global_max;

    logic [`SM_MAX_WIDTH:0]          renorm_shift;
    value_t [`SM_PARALLELISM-1:0]    shifted;
    sum_t                            beat_sum;
    sum_t                            sum_acc;
    recip_t                          recip;

    logic                            div_start;
    recip_t                          div_recip;
    logic                            div_done;

    assign last_beat  = beat_cnt == beat_bits'(`SM_DEPTH - 1);
    assign win_ready  = state == norm_collect;
    assign norm_valid = state == norm_emit;

    // Never negative, global max is at least every local max
    assign renorm_shift = {global_max[`SM_MAX_WIDTH-1], global_max}
                        - {max_mem[beat_cnt][`SM_MAX_WIDTH-1], max_mem[beat_cnt]};

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `SM_PARALLELISM; i++) begin
            shifted[i] = value_mem[beat_cnt][i] >> renorm_shift;
            beat_sum   = beat_sum + sum_t'(shifted[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < `SM_PARALLELISM; i++) begin
            norm_prod[i] = prod_t'(value_mem[beat_cnt][i]) * prod_t'(recip);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= norm_collect;
            beat_cnt  <= '0;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                norm_collect: begin
                    if (win_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            beat_cnt <= '0;
                            state    <= norm_sum;
                        end
                    end
                end
                norm_sum: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        beat_cnt  <= '0;
                        div_start <= 1'b1;
                        state     <= norm_divide;
                    end
                end
                norm_divide: begin
                    if (div_done) begin
                        state <= norm_emit;
                    end
                end
                norm_emit: begin
                    if (norm_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            beat_cnt <= '0;
                            state    <= norm_collect;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            norm_collect: begin
                sum_acc <= '0;
                if (win_valid) begin
                    value_mem[beat_cnt] <= win_values;
                    max_mem[beat_cnt]   <= win_max;
                    if (beat_cnt == '0 || win_max > global_max) begin
                        global_max <= win_max;
                    end
                end
            end
            norm_sum: begin
                // Stored values become relative to the global max
                value_mem[beat_cnt] <= shifted;
                sum_acc             <= sum_acc + beat_sum;
            end
            norm_divide: begin
                if (div_done) begin
                    recip <= div_recip;
                end
            end
            default: begin
            end
        endcase
    end

    softermax_norm_divider norm_divider_inst (
        .clk       (clk),
        .reset     (reset),
        .div_start (div_start),
        .div_sum   (sum_acc),
        .div_recip (div_recip),
        .div_done  (div_done)
    );

endmodule

/* softermax_norm_divider.sv */
// Serial restoring divider giving the Q1.15 reciprocal of the Q6.15 sum
// One quotient bit per cycle, done pulses SM_RECIP_WIDTH+1 cycles after start
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_norm_divider
    import softermax_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      div_start,
    input  sum_t      div_sum,
    output recip_t    div_recip,
    output logic      div_done
);

    localparam int rem_width = `SM_SUM_WIDTH + 1;
    localparam int cnt_width = $clog2(`SM_RECIP_WIDTH);

    logic                    busy;
    logic [cnt_width-1:0]    bit_cnt;
    sum_t                    divisor;
    logic [rem_width-1:0]    rem;
    logic [rem_width-1:0]    trial;
    logic                    fits;

    assign trial = {rem[rem_width-2:0], 1'b0};
    assign fits  = trial >= {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == cnt_width'(`SM_RECIP_WIDTH - 1)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    // Dividend 2^30: the sum is at least 2^15, so the top quotient bits are zero
    // and the walk starts from the remainder 2^14 with all low dividend bits zero
    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor   <= div_sum;
            rem       <= rem_width'(1) << (`SM_RECIP_WIDTH - 2);
            div_recip <= '0;
        end else if (busy) begin
            rem       <= fits ? trial - {1'b0, divisor} : trial;
            div_recip <= {div_recip[`SM_RECIP_WIDTH-2:0], fits};
        end
    end

endmodule

/* softermax_local_window.sv */
// Input stage: integer max of each beat and base-2 lane values relative to it
// One register deep with valid/ready on both sides
`timescale 1ns/100ps
`include "softermax_cfg.svh"

module softermax_local_window
    import softermax_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  in_elem_t [`SM_PARALLELISM-1:0]    in_data,
    input  logic                              in_valid,
    output logic                              in_ready,
    output value_t   [`SM_PARALLELISM-1:0]    win_values,
    output max_t                              win_max,
    output logic                              win_valid,
    input  logic                              win_ready
);

    max_t                            local_max;
    value_t [`SM_PARALLELISM-1:0]    lane_values;

    // Largest floor over the beat
    always_comb begin
        in_elem_t elem;
        max_t     lane_int;
        elem      = in_data[0];
        local_max = max_t'(elem >>> `SM_IN_FRAC);
        for (int i = 1; i < `SM_PARALLELISM; i++) begin
            elem     = in_data[i];
            lane_int = max_t'(elem >>> `SM_IN_FRAC);
            if (lane_int > local_max) begin
                local_max = lane_int;
            end
        end
    end

    // 2^(x - max) with linear fraction, k <= 0 taken as a right shift
    always_comb begin
        in_elem_t                 elem;
        logic [`SM_IN_WIDTH:0]    diff;
        logic [`SM_MAX_WIDTH:0]   shift;
        logic [`SM_IN_FRAC-1:0]   frac;
        value_t                   mant;
        for (int i = 0; i < `SM_PARALLELISM; i++) begin
            elem  = in_data[i];
            diff  = {elem[`SM_IN_WIDTH-1], elem}
                  - {local_max[`SM_MAX_WIDTH-1], local_max, {`SM_IN_FRAC{1'b0}}};
            shift = -diff[`SM_IN_WIDTH:`SM_IN_FRAC];
            frac  = diff[`SM_IN_FRAC-1:0];
            mant  = {1'b1, frac, {(`SM_VALUE_WIDTH-1-`SM_IN_FRAC){1'b0}}};
            if (shift >= `SM_VALUE_WIDTH) begin
                lane_values[i] = '0;
            end else begin
                lane_values[i] = mant >> shift;
            end
        end
    end

    assign in_ready = !win_valid || win_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else if (in_ready) begin
            win_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            win_values <= lane_values;
            win_max    <= local_max;
        end
    end

endmodule

/* softermax_pkg.sv */
// Shared vector types and the normalizer state encoding
// Imported by every RTL module and by the checker
`include "softermax_cfg.svh"

package softermax_pkg;

    typedef logic signed [`SM_IN_WIDTH-1:0]    in_elem_t;
    typedef logic signed [`SM_MAX_WIDTH-1:0]   max_t;
    typedef logic [`SM_VALUE_WIDTH-1:0]        value_t;
    typedef logic [`SM_SUM_WIDTH-1:0]          sum_t;
    typedef logic [`SM_RECIP_WIDTH-1:0]        recip_t;

    // Q2.30 value times reciprocal
    typedef logic [`SM_VALUE_WIDTH+`SM_RECIP_WIDTH-1:0] prod_t;

    typedef logic [`SM_OUT_WIDTH-1:0]          out_elem_t;

    typedef enum logic [1:0] {
        norm_collect,
        norm_sum,
        norm_divide,
        norm_emit
    } norm_state_t;

endpackage

/* softermax_cfg.svh */
// Dimensions and fixed-point widths of the softmax unit
// Included by the RTL, the package and the testbench
`ifndef SOFTERMAX_CFG_SVH
`define SOFTERMAX_CFG_SVH

// Vector shape
`define SM_TOTAL_DIM     16
`define SM_PARALLELISM   4
`define SM_DEPTH         (`SM_TOTAL_DIM / `SM_PARALLELISM)

// Signed input, 3 fraction bits
`define SM_IN_WIDTH      8
`define SM_IN_FRAC       3

// Integer part of the input only
`define SM_MAX_WIDTH     5

// Unsigned Q1.15 base-2 values and Q6.15 sum
`define SM_VALUE_WIDTH   16
`define SM_SUM_WIDTH     21

// Q1.15 reciprocal, Q1.7 result bytes
`define SM_RECIP_WIDTH   16
`define SM_OUT_WIDTH     8

`endif
